// File: files.f
+incdir+hw
hw/axi_pkg.sv
hw/if_axi_master.sv
hw/ls_axi_master.sv
hw/axi_crossbar.sv
hw/axi_sram.sv
hw/axi_mem_top.sv
bench/tb_axi_mem.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_axi_mem -f files.f &&
./obj_dir/Vtb_axi_mem || exit 1

// File: bench/tb_axi_mem.sv
`include "axi_defs_params.svh"

module tb_axi_mem;

    localparam int N_OPS       = 400;
    localparam int N_INIT      = 8;
    localparam int N_RAND      = N_OPS - N_INIT - `SRAM_WORDS;  // rest is the final sweep
    localparam int CYCLE_LIMIT = N_OPS * 16;
    localparam int IDX_W       = $clog2(`SRAM_WORDS);
    localparam int LONE_LAT    = 4;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       fetch_req_i;
    logic [`AXI_ADDR_WIDTH-1:0] fetch_pc_i;
    logic                       fetch_done_o;
    logic [`AXI_DATA_WIDTH-1:0] fetch_instr_o;
    logic                       fetch_err_o;
    logic                       ls_req_i;
    logic                       ls_we_i;
    logic [`AXI_ADDR_WIDTH-1:0] ls_addr_i;
    logic [`AXI_DATA_WIDTH-1:0] ls_wdata_i;
    logic [`AXI_STRB_WIDTH-1:0] ls_wstrb_i;
    logic                       ls_done_o;
    logic [`AXI_DATA_WIDTH-1:0] ls_rdata_o;
    logic                       ls_err_o;

    logic [`AXI_DATA_WIDTH-1:0] model [`SRAM_WORDS];
    int                         seed = 36271;
    int                         cycle_cnt = 0;

    axi_mem_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            stop_on_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            stop_on_error($sformatf("Mismatch %s: got %08h, expected %08h", sig, got, exp));
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        assert (got === exp) else
            stop_on_error($sformatf("Mismatch %s: got %0h, expected %0h", sig, got, exp));
    endtask

    task automatic check_latency(input string what, input int lat);
        assert (lat == LONE_LAT) else
            stop_on_error($sformatf("%s took %0d cycles instead of %0d", what, lat, LONE_LAT));
    endtask

    function automatic bit in_range(input logic [31:0] addr);
        return addr[`AXI_ADDR_WIDTH-1:2] < `SRAM_WORDS;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        return in_range(addr) ? model[addr[IDX_W+1:2]] : '0;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < `AXI_STRB_WIDTH; b++)
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        return res;
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        logic [31:0] addr;
        r = $random(seed);
        addr = '0;
        if (r[8])
            addr[IDX_W+1:2] = r[IDX_W-1:0];
        else
            addr[5:2] = r[3:0];  // small window so loads hit stored words
        return addr;
    endfunction

    function automatic logic [31:0] pick_bad_addr();
        logic [31:0] addr;
        addr = $random(seed);
        addr[1:0] = 2'b00;
        addr[IDX_W+2] = 1'b1;  // word index at or above the depth
        return addr;
    endfunction

    // done cannot rise before the request is sampled, so counting starts at 1
    task automatic wait_done(input bit fetch_side, output int lat);
        lat = 1;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!(fetch_side ? fetch_done_o : ls_done_o));
    endtask

    task automatic load_word(input logic [31:0] addr);
        int lat;
        @(posedge clk_i);
        ls_req_i  <= 1'b1;
        ls_we_i   <= 1'b0;
        ls_addr_i <= addr;
        @(posedge clk_i);
        ls_req_i <= 1'b0;
        wait_done(1'b0, lat);
        check_latency("load", lat);
        check_value("ls_rdata_o", ls_rdata_o, expected_read(addr));
        check_flag("ls_err_o", ls_err_o, !in_range(addr));
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int lat;
        if (in_range(addr))
            model[addr[IDX_W+1:2]] = merge_bytes(model[addr[IDX_W+1:2]], data, strb);
        @(posedge clk_i);
        ls_req_i   <= 1'b1;
        ls_we_i    <= 1'b1;
        ls_addr_i  <= addr;
        ls_wdata_i <= data;
        ls_wstrb_i <= strb;
        @(posedge clk_i);
        ls_req_i <= 1'b0;
        wait_done(1'b0, lat);
        check_latency("store", lat);
        check_flag("ls_err_o", ls_err_o, !in_range(addr));
    endtask

    task automatic fetch_word(input logic [31:0] addr);
        int lat;
        @(posedge clk_i);
        fetch_req_i <= 1'b1;
        fetch_pc_i  <= addr;
        @(posedge clk_i);
        fetch_req_i <= 1'b0;
        wait_done(1'b1, lat);
        check_latency("fetch", lat);
        check_value("fetch_instr_o", fetch_instr_o, expected_read(addr));
        check_flag("fetch_err_o", fetch_err_o, !in_range(addr));
    endtask

    // both masters start on the same edge and fight for AR
    task automatic fetch_with_load(input logic [31:0] faddr, input logic [31:0] laddr);
        int lat;
        int f_at;
        int l_at;
        int f_cnt;
        int l_cnt;
        f_cnt = 0;
        l_cnt = 0;
        f_at  = 0;
        l_at  = 0;
        @(posedge clk_i);
        fetch_req_i <= 1'b1;
        fetch_pc_i  <= faddr;
        ls_req_i    <= 1'b1;
        ls_we_i     <= 1'b0;
        ls_addr_i   <= laddr;
        @(posedge clk_i);
        fetch_req_i <= 1'b0;
        ls_req_i    <= 1'b0;
        lat = 1;
        while (f_cnt == 0 || l_cnt == 0) begin
            @(negedge clk_i);
            lat++;
            if (fetch_done_o) begin
                f_cnt++;
                f_at = lat;
                check_value("fetch_instr_o", fetch_instr_o, expected_read(faddr));
                check_flag("fetch_err_o", fetch_err_o, 1'b0);
            end
            if (ls_done_o) begin
                l_cnt++;
                l_at = lat;
                check_value("ls_rdata_o", ls_rdata_o, expected_read(laddr));
                check_flag("ls_err_o", ls_err_o, 1'b0);
            end
        end
        repeat (2) begin
            @(negedge clk_i);
            if (fetch_done_o)
                f_cnt++;
            if (ls_done_o)
                l_cnt++;
        end
        assert (f_cnt == 1 && l_cnt == 1) else
            stop_on_error($sformatf("fetch and load finished %0d and %0d times, not once each",
                                    f_cnt, l_cnt));
        assert (f_at <= l_at) else
            stop_on_error("fetch finished after the load it competed with");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] addr2;
        logic [31:0] data;
        rst_n_i     = 1'b0;
        fetch_req_i = 1'b0;
        fetch_pc_i  = '0;
        ls_req_i    = 1'b0;
        ls_we_i     = 1'b0;
        ls_addr_i   = '0;
        ls_wdata_i  = '0;
        ls_wstrb_i  = '0;
        for (int i = 0; i < `SRAM_WORDS; i++)
            model[i] = '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        repeat (4) begin  // quiet after reset
            @(negedge clk_i);
            check_flag("fetch_done_o", fetch_done_o, 1'b0);
            check_flag("ls_done_o", ls_done_o, 1'b0);
        end
        for (int n = 0; n < N_INIT; n++)
            load_word(pick_addr());

        for (int n = 0; n < N_RAND; n++) begin
            r     = $random(seed);
            addr  = pick_addr();
            addr2 = pick_addr();
            data  = $random(seed);
            case (r[2:0])
                3'd0, 3'd1: store_word(addr, data, r[7:4]);
                3'd2: load_word(addr);
                3'd3: fetch_word(addr);
                3'd4, 3'd5: fetch_with_load(addr, addr2);
                default: begin
                    addr = pick_bad_addr();
                    if (r[4:3] == 2'd0)
                        load_word(addr);
                    else if (r[4:3] == 2'd1)
                        store_word(addr, data, r[8:5]);
                    else
                        fetch_word(addr);
                end
            endcase
        end

        for (int i = 0; i < `SRAM_WORDS; i++) begin  // whole memory against the model
            addr = '0;
            addr[IDX_W+1:2] = i[IDX_W-1:0];
            load_word(addr);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: hw/axi_mem_top.sv
`include "axi_defs_params.svh"

module axi_mem_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       fetch_req_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] fetch_pc_i,
    output logic                       fetch_done_o,
    output logic [`AXI_DATA_WIDTH-1:0] fetch_instr_o,
    output logic                       fetch_err_o,
    input  logic                       ls_req_i,
    input  logic                       ls_we_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] ls_addr_i,
    input  logic [`AXI_DATA_WIDTH-1:0] ls_wdata_i,
    input  logic [`AXI_STRB_WIDTH-1:0] ls_wstrb_i,
    output logic                       ls_done_o,
    output logic [`AXI_DATA_WIDTH-1:0] ls_rdata_o,
    output logic                       ls_err_o
);

    logic                       if_axi_ar_valid, if_axi_ar_ready, if_axi_r_valid, if_axi_r_ready;
    logic [`AXI_ADDR_WIDTH-1:0] if_axi_ar_addr;
    logic [`AXI_DATA_WIDTH-1:0] if_axi_r_data;
    axi_pkg::axi_resp_e         if_axi_r_resp;

    logic                       ls_axi_ar_valid, ls_axi_ar_ready, ls_axi_r_valid, ls_axi_r_ready;
    logic                       ls_axi_aw_valid, ls_axi_aw_ready, ls_axi_w_valid, ls_axi_w_ready;
    logic                       ls_axi_b_valid, ls_axi_b_ready;
    logic [`AXI_ADDR_WIDTH-1:0] ls_axi_ar_addr, ls_axi_aw_addr;
    logic [`AXI_DATA_WIDTH-1:0] ls_axi_r_data, ls_axi_w_data;
    logic [`AXI_STRB_WIDTH-1:0] ls_axi_w_strb;
    axi_pkg::axi_resp_e         ls_axi_r_resp, ls_axi_b_resp;

    logic                       axi_ar_valid, axi_ar_ready, axi_r_valid, axi_r_ready;
    logic                       axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready;
    logic                       axi_b_valid, axi_b_ready;
    logic [`AXI_ADDR_WIDTH-1:0] axi_ar_addr, axi_aw_addr;
    logic [`AXI_DATA_WIDTH-1:0] axi_r_data, axi_w_data;
    logic [`AXI_STRB_WIDTH-1:0] axi_w_strb;
    logic [`AXI_ID_WIDTH-1:0]   axi_ar_id, axi_r_id, axi_b_id;
    axi_pkg::axi_resp_e         axi_r_resp, axi_b_resp;

    if_axi_master u_if_master (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .fetch_req_i(fetch_req_i), .fetch_pc_i(fetch_pc_i),
        .fetch_done_o(fetch_done_o), .fetch_instr_o(fetch_instr_o), .fetch_err_o(fetch_err_o),
        .if_axi_ar_valid_o(if_axi_ar_valid), .if_axi_ar_ready_i(if_axi_ar_ready),
        .if_axi_ar_addr_o(if_axi_ar_addr),
        .if_axi_r_valid_i(if_axi_r_valid), .if_axi_r_ready_o(if_axi_r_ready),
        .if_axi_r_data_i(if_axi_r_data), .if_axi_r_resp_i(if_axi_r_resp)
    );

    ls_axi_master u_ls_master (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .ls_req_i(ls_req_i), .ls_we_i(ls_we_i), .ls_addr_i(ls_addr_i),
        .ls_wdata_i(ls_wdata_i), .ls_wstrb_i(ls_wstrb_i),
        .ls_done_o(ls_done_o), .ls_rdata_o(ls_rdata_o), .ls_err_o(ls_err_o),
        .ls_axi_ar_valid_o(ls_axi_ar_valid), .ls_axi_ar_ready_i(ls_axi_ar_ready),
        .ls_axi_ar_addr_o(ls_axi_ar_addr),
        .ls_axi_r_valid_i(ls_axi_r_valid), .ls_axi_r_ready_o(ls_axi_r_ready),
        .ls_axi_r_data_i(ls_axi_r_data), .ls_axi_r_resp_i(ls_axi_r_resp),
        .ls_axi_aw_valid_o(ls_axi_aw_valid), .ls_axi_aw_ready_i(ls_axi_aw_ready),
        .ls_axi_aw_addr_o(ls_axi_aw_addr),
        .ls_axi_w_valid_o(ls_axi_w_valid), .ls_axi_w_ready_i(ls_axi_w_ready),
        .ls_axi_w_data_o(ls_axi_w_data), .ls_axi_w_strb_o(ls_axi_w_strb),
        .ls_axi_b_valid_i(ls_axi_b_valid), .ls_axi_b_ready_o(ls_axi_b_ready),
        .ls_axi_b_resp_i(ls_axi_b_resp)
    );

    axi_crossbar u_xbar (
        .if_axi_ar_valid_i(if_axi_ar_valid), .if_axi_ar_ready_o(if_axi_ar_ready),
        .if_axi_ar_addr_i(if_axi_ar_addr),
        .if_axi_r_valid_o(if_axi_r_valid), .if_axi_r_ready_i(if_axi_r_ready),
        .if_axi_r_data_o(if_axi_r_data), .if_axi_r_resp_o(if_axi_r_resp),
        .ls_axi_ar_valid_i(ls_axi_ar_valid), .ls_axi_ar_ready_o(ls_axi_ar_ready),
        .ls_axi_ar_addr_i(ls_axi_ar_addr),
        .ls_axi_r_valid_o(ls_axi_r_valid), .ls_axi_r_ready_i(ls_axi_r_ready),
        .ls_axi_r_data_o(ls_axi_r_data), .ls_axi_r_resp_o(ls_axi_r_resp),
        .ls_axi_aw_valid_i(ls_axi_aw_valid), .ls_axi_aw_ready_o(ls_axi_aw_ready),
        .ls_axi_aw_addr_i(ls_axi_aw_addr),
        .ls_axi_w_valid_i(ls_axi_w_valid), .ls_axi_w_ready_o(ls_axi_w_ready),
        .ls_axi_w_data_i(ls_axi_w_data), .ls_axi_w_strb_i(ls_axi_w_strb),
        .ls_axi_b_valid_o(ls_axi_b_valid), .ls_axi_b_ready_i(ls_axi_b_ready),
        .ls_axi_b_resp_o(ls_axi_b_resp),
        .axi_ar_valid_o(axi_ar_valid), .axi_ar_ready_i(axi_ar_ready),
        .axi_ar_addr_o(axi_ar_addr), .axi_ar_id_o(axi_ar_id),
        .axi_r_valid_i(axi_r_valid), .axi_r_ready_o(axi_r_ready),
        .axi_r_data_i(axi_r_data), .axi_r_resp_i(axi_r_resp), .axi_r_id_i(axi_r_id),
        .axi_aw_valid_o(axi_aw_valid), .axi_aw_ready_i(axi_aw_ready),
        .axi_aw_addr_o(axi_aw_addr),
        .axi_w_valid_o(axi_w_valid), .axi_w_ready_i(axi_w_ready),
        .axi_w_data_o(axi_w_data), .axi_w_strb_o(axi_w_strb),
        .axi_b_valid_i(axi_b_valid), .axi_b_ready_o(axi_b_ready),
        .axi_b_resp_i(axi_b_resp), .axi_b_id_i(axi_b_id)
    );

    axi_sram u_sram (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .axi_ar_valid_i(axi_ar_valid), .axi_ar_ready_o(axi_ar_ready),
        .axi_ar_addr_i(axi_ar_addr), .axi_ar_id_i(axi_ar_id),
        .axi_r_valid_o(axi_r_valid), .axi_r_ready_i(axi_r_ready),
        .axi_r_data_o(axi_r_data), .axi_r_resp_o(axi_r_resp), .axi_r_id_o(axi_r_id),
        .axi_aw_valid_i(axi_aw_valid), .axi_aw_ready_o(axi_aw_ready),
        .axi_aw_addr_i(axi_aw_addr),
        .axi_w_valid_i(axi_w_valid), .axi_w_ready_o(axi_w_ready),
        .axi_w_data_i(axi_w_data), .axi_w_strb_i(axi_w_strb),
        .axi_b_valid_o(axi_b_valid), .axi_b_ready_i(axi_b_ready),
        .axi_b_resp_o(axi_b_resp), .axi_b_id_o(axi_b_id)
    );

endmodule

// File: hw/axi_sram.sv
`include "axi_defs_params.svh"

module axi_sram (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       axi_ar_valid_i,
    output logic                       axi_ar_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0] axi_ar_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]   axi_ar_id_i,
    output logic                       axi_r_valid_o,
    input  logic                       axi_r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0] axi_r_data_o,
    output axi_pkg::axi_resp_e         axi_r_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]   axi_r_id_o,
    input  logic                       axi_aw_valid_i,
    output logic                       axi_aw_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0] axi_aw_addr_i,
    input  logic                       axi_w_valid_i,
    output logic                       axi_w_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0] axi_w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0] axi_w_strb_i,
    output logic                       axi_b_valid_o,
    input  logic                       axi_b_ready_i,
    output axi_pkg::axi_resp_e         axi_b_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]   axi_b_id_o
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    logic [`AXI_DATA_WIDTH-1:0] mem [`SRAM_WORDS];
    axi_pkg::sram_state_e       state_q;
    logic                       wr_pend;
    logic                       rd_take;
    logic                       wr_take;
    logic [`AXI_ADDR_WIDTH-3:0] ar_word;
    logic [`AXI_ADDR_WIDTH-3:0] aw_word;
    logic                       ar_ok;
    logic                       aw_ok;

    assign wr_pend        = axi_aw_valid_i && axi_w_valid_i;
    assign axi_aw_ready_o = (state_q == axi_pkg::S_IDLE) && wr_pend;  // writes first
    assign axi_w_ready_o  = axi_aw_ready_o;
    assign axi_ar_ready_o = (state_q == axi_pkg::S_IDLE) && !wr_pend;
    assign wr_take        = axi_aw_ready_o;
    assign rd_take        = axi_ar_valid_i && axi_ar_ready_o;

    assign ar_word = axi_ar_addr_i[`AXI_ADDR_WIDTH-1:2];
    assign aw_word = axi_aw_addr_i[`AXI_ADDR_WIDTH-1:2];
    assign ar_ok   = ar_word < `SRAM_WORDS;
    assign aw_ok   = aw_word < `SRAM_WORDS;

    assign axi_r_valid_o = (state_q == axi_pkg::S_RDATA);
    assign axi_b_valid_o = (state_q == axi_pkg::S_BRESP);
    assign axi_b_id_o    = axi_pkg::ID_LS;  // only load/store writes

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= axi_pkg::S_IDLE;
        end else begin
            case (state_q)
                axi_pkg::S_IDLE: begin
                    if (wr_take)
                        state_q <= axi_pkg::S_BRESP;
                    else if (rd_take)
                        state_q <= axi_pkg::S_RDATA;
                end
                axi_pkg::S_RDATA: begin
                    if (axi_r_ready_i)
                        state_q <= axi_pkg::S_IDLE;
                end
                axi_pkg::S_BRESP: begin
                    if (axi_b_ready_i)
                        state_q <= axi_pkg::S_IDLE;
                end
                default: state_q <= axi_pkg::S_IDLE;
            endcase
        end
    end

    // contents cleared word by word in reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `SRAM_WORDS; i++)
                mem[i] <= '0;
        end else if (wr_take && aw_ok) begin
            for (int b = 0; b < `AXI_STRB_WIDTH; b++)
                if (axi_w_strb_i[b])
                    mem[aw_word[IDX_W-1:0]][8*b +: 8] <= axi_w_data_i[8*b +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_take) begin
            axi_r_data_o <= ar_ok ? mem[ar_word[IDX_W-1:0]] : '0;
            axi_r_resp_o <= ar_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            axi_r_id_o   <= axi_ar_id_i;  // echoed for steering
        end
        if (wr_take)
            axi_b_resp_o <= aw_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    end

    a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(axi_r_valid_o && axi_b_valid_o));

endmodule

// File: hw/axi_crossbar.sv
`include "axi_defs_params.svh"

module axi_crossbar (
    // fetch side uses id 0
    input  logic                       if_axi_ar_valid_i,
    output logic                       if_axi_ar_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0] if_axi_ar_addr_i,
    output logic                       if_axi_r_valid_o,
    input  logic                       if_axi_r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0] if_axi_r_data_o,
    output axi_pkg::axi_resp_e         if_axi_r_resp_o,
    // load/store side uses id 1
    input  logic                       ls_axi_ar_valid_i,
    output logic                       ls_axi_ar_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0] ls_axi_ar_addr_i,
    output logic                       ls_axi_r_valid_o,
    input  logic                       ls_axi_r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0] ls_axi_r_data_o,
    output axi_pkg::axi_resp_e         ls_axi_r_resp_o,
    input  logic                       ls_axi_aw_valid_i,
    output logic                       ls_axi_aw_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0] ls_axi_aw_addr_i,
    input  logic                       ls_axi_w_valid_i,
    output logic                       ls_axi_w_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0] ls_axi_w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0] ls_axi_w_strb_i,
    output logic                       ls_axi_b_valid_o,
    input  logic                       ls_axi_b_ready_i,
    output axi_pkg::axi_resp_e         ls_axi_b_resp_o,
    // memory side
    output logic                       axi_ar_valid_o,
    input  logic                       axi_ar_ready_i,
    output logic [`AXI_ADDR_WIDTH-1:0] axi_ar_addr_o,
    output logic [`AXI_ID_WIDTH-1:0]   axi_ar_id_o,
    input  logic                       axi_r_valid_i,
    output logic                       axi_r_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0] axi_r_data_i,
    input  axi_pkg::axi_resp_e         axi_r_resp_i,
    input  logic [`AXI_ID_WIDTH-1:0]   axi_r_id_i,
    output logic                       axi_aw_valid_o,
    input  logic                       axi_aw_ready_i,
    output logic [`AXI_ADDR_WIDTH-1:0] axi_aw_addr_o,
    output logic                       axi_w_valid_o,
    input  logic                       axi_w_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0] axi_w_data_o,
    output logic [`AXI_STRB_WIDTH-1:0] axi_w_strb_o,
    input  logic                       axi_b_valid_i,
    output logic                       axi_b_ready_o,
    input  axi_pkg::axi_resp_e         axi_b_resp_i,
    input  logic [`AXI_ID_WIDTH-1:0]   axi_b_id_i
);

    logic grant_if;
    logic r_to_ls;

    assign grant_if = if_axi_ar_valid_i;  // fetch has fixed priority
    assign r_to_ls  = axi_r_id_i[0];

    assign axi_ar_valid_o    = grant_if || ls_axi_ar_valid_i;
    assign axi_ar_addr_o     = grant_if ? if_axi_ar_addr_i : ls_axi_ar_addr_i;
    assign axi_ar_id_o       = grant_if ? axi_pkg::ID_IF : axi_pkg::ID_LS;
    assign if_axi_ar_ready_o = grant_if && axi_ar_ready_i;
    assign ls_axi_ar_ready_o = !grant_if && axi_ar_ready_i;

    assign if_axi_r_valid_o = axi_r_valid_i && !r_to_ls;
    assign ls_axi_r_valid_o = axi_r_valid_i && r_to_ls;
    assign if_axi_r_data_o  = axi_r_data_i;
    assign ls_axi_r_data_o  = axi_r_data_i;
    assign if_axi_r_resp_o  = axi_r_resp_i;
    assign ls_axi_r_resp_o  = axi_r_resp_i;
    assign axi_r_ready_o    = r_to_ls ? ls_axi_r_ready_i : if_axi_r_ready_i;  // owner's ready

    // write path belongs to load/store only
    assign axi_aw_valid_o    = ls_axi_aw_valid_i;
    assign axi_aw_addr_o     = ls_axi_aw_addr_i;
    assign ls_axi_aw_ready_o = axi_aw_ready_i;
    assign axi_w_valid_o     = ls_axi_w_valid_i;
    assign axi_w_data_o      = ls_axi_w_data_i;
    assign axi_w_strb_o      = ls_axi_w_strb_i;
    assign ls_axi_w_ready_o  = axi_w_ready_i;
    assign ls_axi_b_valid_o  = axi_b_valid_i;
    assign ls_axi_b_resp_o   = axi_b_resp_i;
    assign axi_b_ready_o     = ls_axi_b_ready_i;

    always_comb begin
        if (axi_r_valid_i)
            a_r_id: assert (axi_r_id_i inside {axi_pkg::ID_IF, axi_pkg::ID_LS});
        if (axi_b_valid_i)
            a_b_id: assert (axi_b_id_i == axi_pkg::ID_LS);
    end

endmodule

// File: hw/ls_axi_master.sv
`include "axi_defs_params.svh"

module ls_axi_master (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       ls_req_i,
    input  logic                       ls_we_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] ls_addr_i,
    input  logic [`AXI_DATA_WIDTH-1:0] ls_wdata_i,
    input  logic [`AXI_STRB_WIDTH-1:0] ls_wstrb_i,
    output logic                       ls_done_o,
    output logic [`AXI_DATA_WIDTH-1:0] ls_rdata_o,
    output logic                       ls_err_o,
    output logic                       ls_axi_ar_valid_o,
    input  logic                       ls_axi_ar_ready_i,
    output logic [`AXI_ADDR_WIDTH-1:0] ls_axi_ar_addr_o,
    input  logic                       ls_axi_r_valid_i,
    output logic                       ls_axi_r_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0] ls_axi_r_data_i,
    input  axi_pkg::axi_resp_e         ls_axi_r_resp_i,
    output logic                       ls_axi_aw_valid_o,
    input  logic                       ls_axi_aw_ready_i,
    output logic [`AXI_ADDR_WIDTH-1:0] ls_axi_aw_addr_o,
    output logic                       ls_axi_w_valid_o,
    input  logic                       ls_axi_w_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0] ls_axi_w_data_o,
    output logic [`AXI_STRB_WIDTH-1:0] ls_axi_w_strb_o,
    input  logic                       ls_axi_b_valid_i,
    output logic                       ls_axi_b_ready_o,
    input  axi_pkg::axi_resp_e         ls_axi_b_resp_i
);

    axi_pkg::mst_state_e        state_q;
    logic                       we_q;
    logic                       aw_pend_q;
    logic                       w_pend_q;
    logic [`AXI_ADDR_WIDTH-1:0] addr_q;
    logic                       req_take;
    logic                       r_hs;
    logic                       b_hs;
    logic                       wr_sent;

    assign req_take = (state_q == axi_pkg::M_IDLE) && ls_req_i;
    assign r_hs     = ls_axi_r_valid_i && ls_axi_r_ready_o;
    assign b_hs     = ls_axi_b_valid_i && ls_axi_b_ready_o;
    // both write channels done once each has handshaken at some point
    assign wr_sent  = (!aw_pend_q || ls_axi_aw_ready_i) && (!w_pend_q || ls_axi_w_ready_i);

    assign ls_axi_ar_valid_o = (state_q == axi_pkg::M_ADDR) && !we_q;
    assign ls_axi_ar_addr_o  = addr_q;
    assign ls_axi_aw_valid_o = aw_pend_q;
    assign ls_axi_aw_addr_o  = addr_q;
    assign ls_axi_w_valid_o  = w_pend_q;
    assign ls_axi_r_ready_o  = (state_q == axi_pkg::M_RESP) && !we_q;
    assign ls_axi_b_ready_o  = (state_q == axi_pkg::M_RESP) && we_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= axi_pkg::M_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            ls_done_o <= 1'b0;
        end else begin
            ls_done_o <= r_hs || b_hs;
            case (state_q)
                axi_pkg::M_IDLE: begin
                    if (ls_req_i) begin
                        state_q   <= axi_pkg::M_ADDR;
                        aw_pend_q <= ls_we_i;
                        w_pend_q  <= ls_we_i;
                    end
                end
                axi_pkg::M_ADDR: begin
                    if (we_q) begin
                        aw_pend_q <= aw_pend_q && !ls_axi_aw_ready_i;  // drops on own handshake
                        w_pend_q  <= w_pend_q && !ls_axi_w_ready_i;
                        if (wr_sent)
                            state_q <= axi_pkg::M_RESP;
                    end else if (ls_axi_ar_ready_i) begin
                        state_q <= axi_pkg::M_RESP;
                    end
                end
                axi_pkg::M_RESP: begin
                    if (r_hs || b_hs)
                        state_q <= axi_pkg::M_IDLE;
                end
                default: state_q <= axi_pkg::M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_take) begin
            we_q            <= ls_we_i;
            addr_q          <= ls_addr_i;
            ls_axi_w_data_o <= ls_wdata_i;
            ls_axi_w_strb_o <= ls_wstrb_i;
        end
        if (r_hs)
            ls_rdata_o <= ls_axi_r_data_i;
        if (r_hs || b_hs)
            ls_err_o <= r_hs ? (ls_axi_r_resp_i == axi_pkg::RESP_SLVERR)
                             : (ls_axi_b_resp_i == axi_pkg::RESP_SLVERR);
    end

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ls_req_i |-> state_q == axi_pkg::M_IDLE);

endmodule

// File: hw/if_axi_master.sv
`include "axi_defs_params.svh"

module if_axi_master (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       fetch_req_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] fetch_pc_i,
    output logic                       fetch_done_o,
    output logic [`AXI_DATA_WIDTH-1:0] fetch_instr_o,
    output logic                       fetch_err_o,
    output logic                       if_axi_ar_valid_o,
    input  logic                       if_axi_ar_ready_i,
    output logic [`AXI_ADDR_WIDTH-1:0] if_axi_ar_addr_o,
    input  logic                       if_axi_r_valid_i,
    output logic                       if_axi_r_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0] if_axi_r_data_i,
    input  axi_pkg::axi_resp_e         if_axi_r_resp_i
);

    axi_pkg::mst_state_e state_q;
    logic                r_hs;

    assign if_axi_ar_valid_o = (state_q == axi_pkg::M_ADDR);
    assign if_axi_r_ready_o  = (state_q == axi_pkg::M_RESP);
    assign r_hs              = if_axi_r_valid_i && if_axi_r_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= axi_pkg::M_IDLE;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= r_hs;  // one cycle after the R handshake
            case (state_q)
                axi_pkg::M_IDLE: begin
                    if (fetch_req_i)
                        state_q <= axi_pkg::M_ADDR;
                end
                axi_pkg::M_ADDR: begin
                    if (if_axi_ar_ready_i)
                        state_q <= axi_pkg::M_RESP;
                end
                axi_pkg::M_RESP: begin
                    if (r_hs)
                        state_q <= axi_pkg::M_IDLE;
                end
                default: state_q <= axi_pkg::M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == axi_pkg::M_IDLE && fetch_req_i)
            if_axi_ar_addr_o <= fetch_pc_i;
        if (r_hs) begin
            fetch_instr_o <= if_axi_r_data_i;
            fetch_err_o   <= (if_axi_r_resp_i == axi_pkg::RESP_SLVERR);
        end
    end

    // address must survive back-pressure from the crossbar
    a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        if_axi_ar_valid_o && !if_axi_ar_ready_i |=>
            if_axi_ar_valid_o && $stable(if_axi_ar_addr_o));

endmodule

// File: hw/axi_pkg.sv
`include "axi_defs_params.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [`AXI_ID_WIDTH-1:0] {
        ID_IF = 'd0,  // instruction fetch
        ID_LS = 'd1   // load/store
    } axi_id_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_RESP
    } mst_state_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RDATA,
        S_BRESP
    } sram_state_e;

endpackage

// File: hw/axi_defs_params.svh
`ifndef AXI_DEFS_PARAMS_SVH
`define AXI_DEFS_PARAMS_SVH

`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)  // one bit per byte lane
`define AXI_ID_WIDTH   1

`define SRAM_WORDS     256  // word index at or above this is out of range

`endif
